/* hw/iccm_pkg.sv */
// ICCM shared definitions
// Bank geometry, stored word and pair types, operations, access strobe and
// controller states
`default_nettype none

package iccm_pkg;

   //**************************************************************************
   // Geometry
   //**************************************************************************
   localparam int ICCM_NUM_BANKS = 4;
   localparam int ICCM_BANK_BITS = 2;    // Word index bits that pick the bank
   localparam int ICCM_WORD_W    = 39;   // Stored width of an opaque word
   localparam int ICCM_DATA_W    = 32;   // Instruction bits in the low part of a word

   typedef logic [ICCM_WORD_W-1:0] iccm_word_t;

   // lo word at the address and hi word at the next word index
   typedef struct packed {
      iccm_word_t hi;
      iccm_word_t lo;
   } iccm_pair_t;

   //**************************************************************************
   // Operations and strobes
   //**************************************************************************
   typedef enum logic [1:0] {
      ICCM_OP_READ     = 2'b00,
      ICCM_OP_WR_WORD  = 2'b01,
      ICCM_OP_WR_DWORD = 2'b10,   // 8-byte aligned only
      ICCM_OP_CORRECT  = 2'b11    // Load a redundant row
   } iccm_op_e;

   // One-cycle access strobe from the controller
   typedef struct packed {
      logic wren;
      logic rden;
      logic correct;
      logic dword;     // Write covers the next word too
   } iccm_access_t;

   typedef enum logic [1:0] {
      ST_IDLE   = 2'b00,
      ST_ACCESS = 2'b01,
      ST_DATA   = 2'b10,
      ST_ACK    = 2'b11
   } iccm_ctrl_state_e;

endpackage

`default_nettype wire

/* hw/iccm_access_ctrl.sv */
// ICCM access controller
// Four-phase req/ack handshake, one access strobe per transaction and
// registered read results
`timescale 1ns/1ps
`default_nettype none

module iccm_access_ctrl
   import iccm_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         req,
   input  iccm_op_e     op,
   output logic         ack,
   output iccm_access_t acc,
   input  logic [63:0]  rd_data_in,
   input  iccm_pair_t   pair_in,
   output logic [63:0]  rd_data,
   output iccm_pair_t   rd_data_ecc
);

   iccm_ctrl_state_e state, state_nxt;

   // IDLE -> ACCESS (strobe) -> DATA (banks valid) -> ACK
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (req) begin
               state_nxt = ST_ACCESS;
            end
         end
         ST_ACCESS: state_nxt = ST_DATA;
         ST_DATA:   state_nxt = ST_ACK;
         ST_ACK: begin
            if (!req) begin      // Hold here while req stays high
               state_nxt = ST_IDLE;
            end
         end
         default:   state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Strobe decode from the op the requester holds stable
   always_comb begin
      acc = '0;
      if (state == ST_ACCESS) begin
         acc.wren    = (op == ICCM_OP_WR_WORD) || (op == ICCM_OP_WR_DWORD);
         acc.rden    = (op == ICCM_OP_READ);
         acc.correct = (op == ICCM_OP_CORRECT);
         acc.dword   = (op == ICCM_OP_WR_DWORD);
      end
   end

   // Read results only and held across writes and corrects
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_data     <= '0;
         rd_data_ecc <= '0;
      end else if ((state == ST_DATA) && (op == ICCM_OP_READ)) begin
         rd_data     <= rd_data_in;
         rd_data_ecc <= pair_in;
      end
   end

   // Up on the third edge counting the one that samples req
   assign ack = (state == ST_ACK);

endmodule

`default_nettype wire

/* hw/iccm_bank_decode.sv */
// ICCM bank decode
// Computes the next word index, per-bank enables and row addresses, and
// steers the two write legs to their banks
`timescale 1ns/1ps
`default_nettype none

module iccm_bank_decode
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS = 12
) (
   input  iccm_access_t                                            acc,
   input  logic [ICCM_BITS-1:1]                                    addr,
   input  iccm_pair_t                                              wr_data,
   output logic [ICCM_NUM_BANKS-1:0]                               bank_en,
   output logic [ICCM_NUM_BANKS-1:0]                               bank_we,
   output logic [ICCM_NUM_BANKS-1:0][ICCM_BITS-3-ICCM_BANK_BITS:0] bank_row,
   output iccm_word_t [ICCM_NUM_BANKS-1:0]                         bank_wdata
);

   localparam int IDX_W = ICCM_BITS - 2;             // Word index width
   localparam int ROW_W = IDX_W - ICCM_BANK_BITS;    // Row inside a bank

   logic [IDX_W-1:0]          word_idx;
   logic [IDX_W-1:0]          next_idx;
   logic [ICCM_BANK_BITS-1:0] word_bank;
   logic [ICCM_BANK_BITS-1:0] next_bank;
   logic [ROW_W-1:0]          word_row;
   logic [ROW_W-1:0]          next_row;
   logic                      use_word;
   logic                      use_next;

   assign word_idx  = addr[ICCM_BITS-1:2];
   assign next_idx  = word_idx + 1'b1;     // Bank 3 wraps to bank 0 of the next row
   assign word_bank = word_idx[ICCM_BANK_BITS-1:0];
   assign next_bank = next_idx[ICCM_BANK_BITS-1:0];
   assign word_row  = word_idx[IDX_W-1:ICCM_BANK_BITS];
   assign next_row  = next_idx[IDX_W-1:ICCM_BANK_BITS];

   // Corrects touch no bank
   assign use_word = acc.rden | acc.wren;
   assign use_next = acc.rden | (acc.wren & acc.dword);

   //**************************************************************************
   // Per-bank steering
   //**************************************************************************
   for (genvar i = 0; i < ICCM_NUM_BANKS; i++) begin : g_bank
      logic is_word;
      logic is_next;

      assign is_word = (word_bank == ICCM_BANK_BITS'(i));
      assign is_next = (next_bank == ICCM_BANK_BITS'(i));

      assign bank_en[i]    = (use_word & is_word) | (use_next & is_next);
      assign bank_we[i]    = acc.wren & bank_en[i];
      assign bank_row[i]   = is_next ? next_row : word_row;
      assign bank_wdata[i] = is_word ? wr_data.lo : wr_data.hi;   // lo leg to word bank
   end

endmodule

`default_nettype wire

/* hw/iccm_bank_ram.sv */
// ICCM bank RAM
// Behavioral single-port synchronous RAM, one 39-bit word per row
`timescale 1ns/1ps
`default_nettype none

module iccm_bank_ram
   import iccm_pkg::*;
#(
   parameter int ROW_BITS = 8
) (
   input  logic                clk,
   input  logic                en,
   input  logic                we,
   input  logic [ROW_BITS-1:0] row,
   input  iccm_word_t          din,
   output iccm_word_t          dout
);

   iccm_word_t mem [(1 << ROW_BITS)];

   // Read data a cycle after enable and held otherwise
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[row] <= din;
         end else begin
            dout <= mem[row];
         end
      end
   end

endmodule

`default_nettype wire

/* hw/iccm_redundancy.sv */
// ICCM redundant rows
// Two spare words replace faulty locations, refilled in LRU order, kept in
// step with later writes and substituted into bank read data
`timescale 1ns/1ps
`default_nettype none

module iccm_redundancy
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS = 12
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  iccm_access_t                   acc,
   input  logic [ICCM_BITS-1:1]           addr,
   input  iccm_pair_t                     wr_data,
   input  iccm_word_t [ICCM_NUM_BANKS-1:0] bank_raw,
   output iccm_word_t [ICCM_NUM_BANKS-1:0] bank_fixed
);

   localparam int IDX_W = ICCM_BITS - 2;

   typedef struct packed {
      logic             valid;
      logic [IDX_W-1:0] idx;    // Full word index
      iccm_word_t       data;
   } red_row_t;

   red_row_t [1:0]                 row_q;
   red_row_t [1:0]                 row_d;
   logic                           lru_q;   // Row to refill next
   logic                           lru_d;
   logic [IDX_W-1:0]               word_idx;
   logic [IDX_W-1:0]               next_idx;
   logic [1:0]                     hit_word;
   logic [1:0]                     hit_next;
   logic [1:0][ICCM_NUM_BANKS-1:0] sel;
   logic [1:0][ICCM_NUM_BANKS-1:0] sel_q;

   assign word_idx = addr[ICCM_BITS-1:2];
   assign next_idx = word_idx + 1'b1;

   for (genvar r = 0; r < 2; r++) begin : g_hit
      assign hit_word[r] = row_q[r].valid & (row_q[r].idx == word_idx);
      assign hit_next[r] = row_q[r].valid & (row_q[r].idx == next_idx);
   end

   //**************************************************************************
   // Row state
   //**************************************************************************
   always_comb begin
      row_d = row_q;
      lru_d = lru_q;
      // Follow writes to a row's word
      for (int r = 0; r < 2; r++) begin
         if (acc.wren && hit_word[r]) begin
            row_d[r].data = wr_data.lo;
         end else if (acc.wren && acc.dword && hit_next[r]) begin
            row_d[r].data = wr_data.hi;
         end
      end
      if (acc.correct) begin
         row_d[lru_q].valid = 1'b1;
         row_d[lru_q].idx   = word_idx;
         row_d[lru_q].data  = wr_data.lo;
         lru_d              = ~lru_q;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lru_q          <= 1'b0;
         row_q[0].valid <= 1'b0;
         row_q[1].valid <= 1'b0;
      end else begin
         row_q <= row_d;
         lru_q <= lru_d;
      end
   end

   //**************************************************************************
   // Read match and substitution
   //**************************************************************************
   always_comb begin
      for (int r = 0; r < 2; r++) begin
         for (int i = 0; i < ICCM_NUM_BANKS; i++) begin
            sel[r][i] = acc.rden &&
                        ((hit_word[r] && (word_idx[ICCM_BANK_BITS-1:0] ==
                                          ICCM_BANK_BITS'(i))) ||
                         (hit_next[r] && (next_idx[ICCM_BANK_BITS-1:0] ==
                                          ICCM_BANK_BITS'(i))));
         end
      end
   end

   // Same latency as the bank RAM and held between reads
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sel_q <= '0;
      end else if (acc.rden) begin
         sel_q <= sel;
      end
   end

   for (genvar i = 0; i < ICCM_NUM_BANKS; i++) begin : g_sub
      assign bank_fixed[i] = sel_q[1][i] ? row_q[1].data :     // Row 1 wins
                             sel_q[0][i] ? row_q[0].data :
                                           bank_raw[i];
   end

endmodule

`default_nettype wire

/* hw/iccm_read_align.sv */
// ICCM read alignment
// Picks the word and next-word banks, builds the raw pair and the
// halfword-aligned 64-bit instruction data
`timescale 1ns/1ps
`default_nettype none

module iccm_read_align
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS = 12
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [ICCM_BITS-1:1]           addr,
   input  iccm_word_t [ICCM_NUM_BANKS-1:0] bank_fixed,
   output logic [63:0]                    rd_data,
   output iccm_pair_t                     pair
);

   logic [ICCM_BANK_BITS-1:0] next_bank;
   logic [ICCM_BANK_BITS-1:0] word_bank_q;
   logic [ICCM_BANK_BITS-1:0] next_bank_q;
   logic                      half_q;        // Halfword address bit
   iccm_word_t                word_w;
   iccm_word_t                next_w;
   logic [2*ICCM_DATA_W-1:0]  data_pre;

   assign next_bank = addr[ICCM_BANK_BITS+1:2] + 1'b1;

   // Line up with the bank outputs
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         word_bank_q <= '0;
         next_bank_q <= '0;
         half_q      <= 1'b0;
      end else begin
         word_bank_q <= addr[ICCM_BANK_BITS+1:2];
         next_bank_q <= next_bank;
         half_q      <= addr[1];
      end
   end

   assign word_w = bank_fixed[word_bank_q];
   assign next_w = bank_fixed[next_bank_q];
   assign pair   = '{hi: next_w, lo: word_w};

   assign data_pre = {next_w[ICCM_DATA_W-1:0], word_w[ICCM_DATA_W-1:0]};
   assign rd_data  = half_q ? (data_pre >> 16) : data_pre;   // Zero fill on top

endmodule

`default_nettype wire

/* hw/iccm_mem.sv */
// Banked ICCM top level
// Four-phase access port over four bank RAMs with two redundant rows and
// halfword-aligned reads
`timescale 1ns/1ps
`default_nettype none

module iccm_mem
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS = 12   // Byte address width from 10 to 16
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 req,
   input  iccm_op_e             op,
   input  logic [ICCM_BITS-1:1] addr,
   input  iccm_pair_t           wr_data,
   output logic                 ack,
   output logic [63:0]          rd_data,
   output iccm_pair_t           rd_data_ecc
);

   localparam int ROW_BITS = ICCM_BITS - 4;   // Rows per bank

   iccm_access_t                      acc;
   logic [63:0]                       rd_data_al;
   iccm_pair_t                        pair_al;
   logic [ICCM_NUM_BANKS-1:0]         bank_en;
   logic [ICCM_NUM_BANKS-1:0]         bank_we;
   logic [ICCM_NUM_BANKS-1:0][ROW_BITS-1:0] bank_row;
   iccm_word_t [ICCM_NUM_BANKS-1:0]   bank_wdata;
   iccm_word_t [ICCM_NUM_BANKS-1:0]   bank_raw;
   iccm_word_t [ICCM_NUM_BANKS-1:0]   bank_fixed;

   iccm_access_ctrl u_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req),
      .op          (op),
      .ack         (ack),
      .acc         (acc),
      .rd_data_in  (rd_data_al),
      .pair_in     (pair_al),
      .rd_data     (rd_data),
      .rd_data_ecc (rd_data_ecc)
   );

   iccm_bank_decode #(.ICCM_BITS(ICCM_BITS)) u_decode (
      .acc        (acc),
      .addr       (addr),
      .wr_data    (wr_data),
      .bank_en    (bank_en),
      .bank_we    (bank_we),
      .bank_row   (bank_row),
      .bank_wdata (bank_wdata)
   );

   //**************************************************************************
   // Banks
   //**************************************************************************
   for (genvar i = 0; i < ICCM_NUM_BANKS; i++) begin : g_bank
      iccm_bank_ram #(.ROW_BITS(ROW_BITS)) u_ram (
         .clk  (clk),
         .en   (bank_en[i]),
         .we   (bank_we[i]),
         .row  (bank_row[i]),
         .din  (bank_wdata[i]),
         .dout (bank_raw[i])
      );
   end

   iccm_redundancy #(.ICCM_BITS(ICCM_BITS)) u_red (
      .clk        (clk),
      .rst_n      (rst_n),
      .acc        (acc),
      .addr       (addr),
      .wr_data    (wr_data),
      .bank_raw   (bank_raw),
      .bank_fixed (bank_fixed)
   );

   iccm_read_align #(.ICCM_BITS(ICCM_BITS)) u_align (
      .clk        (clk),
      .rst_n      (rst_n),
      .addr       (addr),
      .bank_fixed (bank_fixed),
      .rd_data    (rd_data_al),
      .pair       (pair_al)
   );

endmodule

`default_nettype wire

/* testbench/tb_iccm_mem.sv */
// Testbench for the banked ICCM
// Table-driven four-phase accesses checked against a shadow memory with
// shadow redundant rows, LFSR write data and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_iccm_mem
   import iccm_pkg::*;
();

   localparam int          ICCM_BITS    = 12;
   localparam int          IDX_W        = ICCM_BITS - 2;
   localparam int          CLK_PERIOD   = 10;
   localparam int          RESET_CYCLES = 8;
   localparam int          ACK_EDGES    = 3;    // Edges from req sample to ack high
   localparam int          ACK_LIMIT    = 8;
   localparam int          NUM_STIM     = 37;
   localparam int          WATCHDOG_NS  = (NUM_STIM * 12 + RESET_CYCLES) * CLK_PERIOD;
   localparam logic [31:0] LFSR_SEED    = 32'hcae308a8;

   typedef struct packed {
      iccm_op_e        op;
      logic [11:0]     addr;   // Byte address
      logic [7:0]      tag;    // Behavior group
   } stim_t;

   logic                 clk;
   logic                 rst_n;
   logic                 req;
   iccm_op_e             op;
   logic [ICCM_BITS-1:1] addr;
   iccm_pair_t           wr_data;
   logic                 ack;
   logic [63:0]          rd_data;
   iccm_pair_t           rd_data_ecc;

   stim_t                stim [NUM_STIM];
   logic [31:0]          lfsr;

   // Shadow model
   iccm_word_t           shadow_mem [1 << IDX_W];
   logic                 shadow_written [1 << IDX_W];
   logic                 row_valid [2];
   logic [IDX_W-1:0]     row_idx [2];
   iccm_word_t           row_data [2];
   logic                 lru;

   iccm_mem #(.ICCM_BITS(ICCM_BITS)) u_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req),
      .op          (op),
      .addr        (addr),
      .wr_data     (wr_data),
      .ack         (ack),
      .rd_data     (rd_data),
      .rd_data_ecc (rd_data_ecc)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_pair(output iccm_pair_t p);
      logic [2*ICCM_WORD_W-1:0] bits;
      for (int b = 0; b < 2 * ICCM_WORD_W; b++) begin
         lfsr    = lfsr_next(lfsr);
         bits[b] = lfsr[0];
      end
      p = bits;
   endtask

   function automatic stim_t make_entry(input iccm_op_e o, input logic [11:0] a,
                                        input logic [7:0] t);
      stim_t e;
      e.op   = o;
      e.addr = a;
      e.tag  = t;
      return e;
   endfunction

   //**************************************************************************
   // Stimulus table {op, byte address, behavior group}
   //**************************************************************************
   task automatic load_table();
      stim[0]  = make_entry(ICCM_OP_READ,     12'h100, 8'd1);   // Never written
      stim[1]  = make_entry(ICCM_OP_WR_DWORD, 12'h000, 8'd2);
      stim[2]  = make_entry(ICCM_OP_WR_DWORD, 12'h008, 8'd2);
      stim[3]  = make_entry(ICCM_OP_WR_DWORD, 12'h010, 8'd2);
      stim[4]  = make_entry(ICCM_OP_WR_DWORD, 12'hff8, 8'd2);   // Top two words
      stim[5]  = make_entry(ICCM_OP_READ,     12'h000, 8'd2);
      stim[6]  = make_entry(ICCM_OP_READ,     12'h008, 8'd2);
      stim[7]  = make_entry(ICCM_OP_READ,     12'h010, 8'd2);
      stim[8]  = make_entry(ICCM_OP_READ,     12'hff8, 8'd2);
      stim[9]  = make_entry(ICCM_OP_WR_WORD,  12'h01c, 8'd3);   // Bank 3
      stim[10] = make_entry(ICCM_OP_WR_WORD,  12'h020, 8'd3);   // Bank 0 of the next row
      stim[11] = make_entry(ICCM_OP_WR_WORD,  12'h018, 8'd3);
      stim[12] = make_entry(ICCM_OP_READ,     12'h01c, 8'd3);   // Wraps to bank 0
      stim[13] = make_entry(ICCM_OP_READ,     12'h018, 8'd3);
      stim[14] = make_entry(ICCM_OP_READ,     12'h00c, 8'd3);
      stim[15] = make_entry(ICCM_OP_WR_WORD,  12'h014, 8'd3);
      stim[16] = make_entry(ICCM_OP_READ,     12'h010, 8'd3);
      stim[17] = make_entry(ICCM_OP_READ,     12'hffc, 8'd3);   // Wraps to index 0
      stim[18] = make_entry(ICCM_OP_READ,     12'h01e, 8'd4);
      stim[19] = make_entry(ICCM_OP_READ,     12'h002, 8'd4);
      stim[20] = make_entry(ICCM_OP_READ,     12'hffa, 8'd4);
      stim[21] = make_entry(ICCM_OP_READ,     12'h00e, 8'd4);
      stim[22] = make_entry(ICCM_OP_CORRECT,  12'h010, 8'd5);   // Row 0
      stim[23] = make_entry(ICCM_OP_READ,     12'h010, 8'd5);
      stim[24] = make_entry(ICCM_OP_READ,     12'h00c, 8'd5);   // Row word as hi
      stim[25] = make_entry(ICCM_OP_WR_WORD,  12'h010, 8'd5);   // Bank and row
      stim[26] = make_entry(ICCM_OP_READ,     12'h010, 8'd5);
      stim[27] = make_entry(ICCM_OP_READ,     12'h012, 8'd5);
      stim[28] = make_entry(ICCM_OP_CORRECT,  12'h020, 8'd6);   // Row 1
      stim[29] = make_entry(ICCM_OP_CORRECT,  12'h008, 8'd6);   // Row 0 again
      stim[30] = make_entry(ICCM_OP_CORRECT,  12'h014, 8'd6);   // Evicts 12'h020
      stim[31] = make_entry(ICCM_OP_READ,     12'h01e, 8'd6);
      stim[32] = make_entry(ICCM_OP_READ,     12'h008, 8'd6);
      stim[33] = make_entry(ICCM_OP_READ,     12'h012, 8'd6);
      stim[34] = make_entry(ICCM_OP_READ,     12'h004, 8'd6);
      stim[35] = make_entry(ICCM_OP_WR_DWORD, 12'h010, 8'd6);   // hi leg hits row 1
      stim[36] = make_entry(ICCM_OP_READ,     12'h010, 8'd6);
   endtask

   //**************************************************************************
   // Shadow model
   //**************************************************************************
   function automatic iccm_word_t expected_word(input logic [IDX_W-1:0] idx);
      if (row_valid[1] && (row_idx[1] == idx)) begin
         return row_data[1];                            // Row 1 first
      end
      if (row_valid[0] && (row_idx[0] == idx)) begin
         return row_data[0];
      end
      return shadow_mem[idx];
   endfunction

   function automatic logic word_known(input logic [IDX_W-1:0] idx);
      return shadow_written[idx] || (row_valid[0] && (row_idx[0] == idx)) ||
             (row_valid[1] && (row_idx[1] == idx));
   endfunction

   task automatic update_shadow(input iccm_op_e o, input logic [IDX_W-1:0] idx,
                                input iccm_pair_t d);
      logic [IDX_W-1:0] nidx;
      nidx = idx + 1'b1;
      if (o == ICCM_OP_CORRECT) begin
         row_valid[lru] = 1'b1;
         row_idx[lru]   = idx;
         row_data[lru]  = d.lo;
         lru            = ~lru;
      end else if (o != ICCM_OP_READ) begin
         shadow_mem[idx]     = d.lo;
         shadow_written[idx] = 1'b1;
         if (o == ICCM_OP_WR_DWORD) begin
            shadow_mem[nidx]     = d.hi;
            shadow_written[nidx] = 1'b1;
         end
         for (int r = 0; r < 2; r++) begin   // Rows follow writes
            if (row_valid[r] && (row_idx[r] == idx)) begin
               row_data[r] = d.lo;
            end else if ((o == ICCM_OP_WR_DWORD) && row_valid[r] && (row_idx[r] == nidx)) begin
               row_data[r] = d.hi;
            end
         end
      end
   endtask

   // Four-phase access entered and left on a falling edge
   task automatic run_handshake(input stim_t s, input iccm_pair_t d, input int n);
      int edges;
      assert (!ack) else abort_run($sformatf("Entry %0d: ack was high before req rose", n));
      op      = s.op;
      addr    = s.addr[ICCM_BITS-1:1];
      wr_data = d;
      req     = 1'b1;
      edges   = 0;
      do begin
         @(posedge clk);
         edges++;
         @(negedge clk);
      end while (!ack && (edges < ACK_LIMIT));
      assert (ack) else abort_run($sformatf("Entry %0d: no ack within %0d cycles of req",
                                            n, ACK_LIMIT));
      assert (edges == ACK_EDGES) else
         abort_run($sformatf("[ERROR] %0t ack: rose after %0d edges, expected %0d",
                             $time, edges, ACK_EDGES));
      req   = 1'b0;
      edges = 0;
      do begin
         @(posedge clk);
         edges++;
         @(negedge clk);
      end while (ack && (edges < ACK_LIMIT));
      assert (!ack) else abort_run($sformatf("Entry %0d: ack stayed high after req fell", n));
      assert (edges == 1) else
         abort_run($sformatf("[ERROR] %0t ack: fell after %0d edges, expected 1",
                             $time, edges));
   endtask

   initial begin : watchdog
      #(WATCHDOG_NS);
      abort_run($sformatf("Timeout: the run did not finish within %0d ns", WATCHDOG_NS));
   end

   initial begin : main
      iccm_pair_t       data;
      iccm_pair_t       exp_pair;
      logic [63:0]      exp_data;
      logic [IDX_W-1:0] idx;
      logic             hold_valid;
      logic [63:0]      hold_data;
      iccm_pair_t       hold_pair;
      int               num_checked;

      clk         = 1'b0;
      rst_n       = 1'b0;
      req         = 1'b0;
      op          = ICCM_OP_READ;
      addr        = '0;
      wr_data     = '0;
      lfsr        = LFSR_SEED;
      lru         = 1'b0;
      hold_valid  = 1'b0;
      hold_data   = '0;
      hold_pair   = '0;
      num_checked = 0;
      for (int i = 0; i < (1 << IDX_W); i++) begin
         shadow_mem[i]     = '0;
         shadow_written[i] = 1'b0;
      end
      for (int r = 0; r < 2; r++) begin
         row_valid[r] = 1'b0;
         row_idx[r]   = '0;
         row_data[r]  = '0;
      end
      load_table();

      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      assert (!ack) else abort_run("ack was high right after reset");

      for (int n = 0; n < NUM_STIM; n++) begin
         draw_pair(data);                            // Reads draw data too
         idx = stim[n].addr[ICCM_BITS-1:2];
         run_handshake(stim[n], data, n);
         if (stim[n].op == ICCM_OP_READ) begin
            if (word_known(idx) && word_known(idx + 1'b1)) begin
               exp_pair.lo = expected_word(idx);
               exp_pair.hi = expected_word(idx + 1'b1);
               exp_data    = {exp_pair.hi[ICCM_DATA_W-1:0], exp_pair.lo[ICCM_DATA_W-1:0]};
               if (stim[n].addr[1]) begin
                  exp_data = {16'h0, exp_data[63:16]};   // Halfword start
               end
               assert (rd_data_ecc == exp_pair) else
                  abort_run($sformatf("[ERROR] %0t rd_data_ecc: got %h, expected %h (entry %0d)",
                                      $time, rd_data_ecc, exp_pair, n));
               assert (rd_data == exp_data) else
                  abort_run($sformatf("[ERROR] %0t rd_data: got %h, expected %h (entry %0d)",
                                      $time, rd_data, exp_data, n));
               hold_valid = 1'b1;
               hold_data  = exp_data;
               hold_pair  = exp_pair;
               num_checked++;
            end else begin
               assert (stim[n].tag == 8'd1) else
                  abort_run($sformatf("Entry %0d reads a location that was never written", n));
               hold_valid = 1'b0;
            end
         end else begin
            update_shadow(stim[n].op, idx, data);
            if (hold_valid) begin                    // Last read result must hold
               assert (rd_data == hold_data) else
                  abort_run($sformatf("[ERROR] %0t rd_data: got %h, expected %h (entry %0d)",
                                      $time, rd_data, hold_data, n));
               assert (rd_data_ecc == hold_pair) else
                  abort_run($sformatf("[ERROR] %0t rd_data_ecc: got %h, expected %h (entry %0d)",
                                      $time, rd_data_ecc, hold_pair, n));
            end
         end
      end

      $display("%0d accesses done, %0d reads compared", NUM_STIM, num_checked);
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
hw/iccm_pkg.sv
hw/iccm_access_ctrl.sv
hw/iccm_bank_decode.sv
hw/iccm_bank_ram.sv
hw/iccm_redundancy.sv
hw/iccm_read_align.sv
hw/iccm_mem.sv
testbench/tb_iccm_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the ICCM testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Mdir obj_dir --top-module tb_iccm_mem \
   -f filelist.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_iccm_mem > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -qF "** FAIL **" "$SIM_LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi
if [ "$sim_status" -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi
echo "Simulation finished without failures"
exit 0
